// File: rtl/fp16_mul_pkg.sv
`default_nettype none

package fp16_mul_pkg;

    // Number of multiply lanes working side by side.
    localparam int NUM_LANES = 4;

    // Width of a lane index, used by the issue and collect pointers.
    localparam int LANE_IDX_W = 2;

    // Cycles from a start pulse on a lane to its done pulse.
    // The significand multiplier takes two of them and the output register takes one.
    localparam int LANE_LATENCY = 3;

    // Entries in the result buffer.
    // The upstream producer starts with the same number of credits, so the
    // buffer can never be asked to hold more than it has room for.
    localparam int BUF_DEPTH = 8;

    // Buffer pointer width. BUF_DEPTH is a power of two, so pointers wrap naturally.
    localparam int BUF_IDX_W = 3;

    // Credit and fill counters must be able to hold the value BUF_DEPTH itself.
    localparam int CNT_W = BUF_IDX_W + 1;

    // Credits the downstream consumer grants to the collector at reset.
    localparam int OUT_CREDITS = 4;

    // FP16 field widths.
    localparam int EXP_W  = 5;
    localparam int FRAC_W = 10;

    // Significand width including the implicit leading bit.
    localparam int SIG_W = 11;

    // Exponent bias of the half precision format.
    localparam int FP16_BIAS = 15;

endpackage

`default_nettype wire

// File: rtl/mul_lane_if.sv
`timescale 1ns/10ps
`default_nettype none

// Operand and result bundle for one multiply lane.
interface mul_lane_if;

    // Request side. A start pulse lasts one cycle and carries one operand pair.
    logic        start;
    logic [15:0] a;
    logic [15:0] b;

    // Response side. Done is a one cycle pulse, result and flag are valid with it.
    logic        done;
    logic [15:0] result;
    logic        range_err;

    modport dispatch (output start, output a, output b);

    modport lane (input start, input a, input b,
                  output done, output result, output range_err);

    modport collect (input done, input result, input range_err);

endinterface

`default_nettype wire

// File: rtl/wallacetree_11b_2c.sv
`timescale 1ns/10ps
`default_nettype none

module wallacetree_11b_2c import fp16_mul_pkg::*; (
    input  logic             clk,
    input  logic             nRST,
    input  logic             active,
    input  logic [SIG_W-1:0] a,
    input  logic [SIG_W-1:0] b,
    output logic [12:0]      result,
    output logic             overflow,
    output logic             round_loss,
    output logic             value_ready
);

    // One 3:2 compressor row. The upper half of the return value is the
    // carry vector, already shifted into its weight, the lower half is the sum.
    function automatic logic [4*SIG_W-1:0] csa(input logic [2*SIG_W-1:0] x,
                                               input logic [2*SIG_W-1:0] y,
                                               input logic [2*SIG_W-1:0] z);
        logic [2*SIG_W-1:0] s;
        logic [2*SIG_W-1:0] c;
        s = x ^ y ^ z;
        c = ((x & y) | (x & z) | (y & z)) << 1;
        return {c, s};
    endfunction

    logic [2*SIG_W-1:0] pp   [SIG_W];
    logic [2*SIG_W-1:0] lvl1 [8];
    logic [2*SIG_W-1:0] lvl2 [6];
    logic [2*SIG_W-1:0] lvl3 [4];
    logic [2*SIG_W-1:0] mid_q [4];
    logic               mid_valid;
    logic [2*SIG_W-1:0] lvl4 [3];
    logic [2*SIG_W-1:0] lvl5 [2];
    logic [2*SIG_W-1:0] prod_q;

    // Partial products. Row i is the multiplicand shifted by i when bit i of b is set.
    always_comb begin
        for (int i = 0; i < SIG_W; i++) begin
            pp[i] = b[i] ? ({{SIG_W{1'b0}}, a} << i) : '0;
        end
    end

    // First half of the tree reduces eleven rows to four: 11 -> 8 -> 6 -> 4.
    always_comb begin
        {lvl1[1], lvl1[0]} = csa(pp[0], pp[1], pp[2]);
        {lvl1[3], lvl1[2]} = csa(pp[3], pp[4], pp[5]);
        {lvl1[5], lvl1[4]} = csa(pp[6], pp[7], pp[8]);
        lvl1[6] = pp[9];
        lvl1[7] = pp[10];
        {lvl2[1], lvl2[0]} = csa(lvl1[0], lvl1[1], lvl1[2]);
        {lvl2[3], lvl2[2]} = csa(lvl1[3], lvl1[4], lvl1[5]);
        lvl2[4] = lvl1[6];
        lvl2[5] = lvl1[7];
        {lvl3[1], lvl3[0]} = csa(lvl2[0], lvl2[1], lvl2[2]);
        {lvl3[3], lvl3[2]} = csa(lvl2[3], lvl2[4], lvl2[5]);
    end

    // Valid flags follow the data through both register stages.
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            mid_valid   <= 1'b0;
            value_ready <= 1'b0;
        end else begin
            mid_valid   <= active;
            value_ready <= mid_valid;
        end
    end

    // The four remaining rows are held at the midpoint of the tree.
    always_ff @(posedge clk) begin
        if (active) begin
            mid_q <= lvl3;
        end
    end

    // Second half: 4 -> 3 -> 2 rows, then one carry propagate adder.
    always_comb begin
        {lvl4[1], lvl4[0]} = csa(mid_q[0], mid_q[1], mid_q[2]);
        lvl4[2] = mid_q[3];
        {lvl5[1], lvl5[0]} = csa(lvl4[0], lvl4[1], lvl4[2]);
    end

    always_ff @(posedge clk) begin
        if (mid_valid) begin
            prod_q <= lvl5[0] + lvl5[1];
        end
    end

    // Bit 21 means the significand product reached [2,4).
    assign overflow   = prod_q[21];
    assign result     = prod_q[20:8];
    assign round_loss = |prod_q[7:0];

endmodule

`default_nettype wire

// File: rtl/adder_5b.sv
`timescale 1ns/10ps
`default_nettype none

module adder_5b import fp16_mul_pkg::*; (
    input  logic             carry,
    input  logic [EXP_W-1:0] exp1,
    input  logic [EXP_W-1:0] exp2,
    output logic [EXP_W-1:0] sum,
    output logic             ovf,
    output logic             unf
);

    // Two extra bits keep the raw sum of both biased exponents and the carry exact.
    logic [EXP_W+1:0] raw;
    logic [EXP_W+1:0] unbiased;

    assign raw = {2'b00, exp1} + {2'b00, exp2} + {{(EXP_W+1){1'b0}}, carry};

    // Removing one bias leaves the result in biased form again.
    assign unbiased = raw - (EXP_W+2)'(FP16_BIAS);

    // Largest normal biased exponent is 30, smallest is 1.
    // Comparing the raw sum avoids signed arithmetic on the unbiased value.
    assign ovf = raw > (EXP_W+2)'(2**EXP_W - 2 + FP16_BIAS);
    assign unf = raw < (EXP_W+2)'(1 + FP16_BIAS);

    assign sum = unbiased[EXP_W-1:0];

endmodule

`default_nettype wire

// File: rtl/mul_fp16.sv
`timescale 1ns/10ps
`default_nettype none

module mul_fp16 import fp16_mul_pkg::*; (
    input logic      clk,
    input logic      nRST,
    mul_lane_if.lane lane
);

    // The multiplier latches the operands from the bundle on start and adds two
    // stages, then register 2 feeds the combinational sign, exponent and rounding logic.
    // The dispatcher holds a and b stable for the whole start cycle.

    // The implicit leading bit is one unless the exponent field is zero.
    logic [SIG_W-1:0] sig_a;
    logic [SIG_W-1:0] sig_b;

    assign sig_a = {|lane.a[FRAC_W +: EXP_W], lane.a[FRAC_W-1:0]};
    assign sig_b = {|lane.b[FRAC_W +: EXP_W], lane.b[FRAC_W-1:0]};

    logic              mul_ready;
    logic [FRAC_W+2:0] mul_product;
    logic              mul_carry;
    logic              mul_loss;

    wallacetree_11b_2c u_wallace (
        .clk        (clk),
        .nRST       (nRST),
        .active     (lane.start),
        .a          (sig_a),
        .b          (sig_b),
        .result     (mul_product),
        .overflow   (mul_carry),
        .round_loss (mul_loss),
        .value_ready(mul_ready)
    );

    // Sign and exponent ("head") travel beside the multiplier through a delay
    // line as long as its latency.
    // The line shifts every cycle, so several operations can be in flight at once.
    logic [EXP_W:0] a_head_d [LANE_LATENCY-1];
    logic [EXP_W:0] b_head_d [LANE_LATENCY-1];

    always_ff @(posedge clk) begin
        a_head_d[0] <= lane.a[15:FRAC_W];
        b_head_d[0] <= lane.b[15:FRAC_W];
        for (int i = 1; i < LANE_LATENCY - 1; i++) begin
            a_head_d[i] <= a_head_d[i-1];
            b_head_d[i] <= b_head_d[i-1];
        end
    end

    // Register 2 captures the product and the aligned heads.
    logic              lat2_ready;
    logic [EXP_W:0]    a_head_s2;
    logic [EXP_W:0]    b_head_s2;
    logic [FRAC_W+2:0] prod_s2;
    logic              carry_s2;
    logic              loss_s2;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            lat2_ready <= 1'b0;
        end else begin
            lat2_ready <= mul_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_ready) begin
            a_head_s2 <= a_head_d[LANE_LATENCY-2];
            b_head_s2 <= b_head_d[LANE_LATENCY-2];
            prod_s2   <= mul_product;
            carry_s2  <= mul_carry;
            loss_s2   <= mul_loss;
        end
    end

    // Result sign.
    logic sign_r;
    assign sign_r = a_head_s2[EXP_W] ^ b_head_s2[EXP_W];

    // Exponent sum. The multiplier carry bumps the exponent by one.
    logic [EXP_W-1:0] exp_sum;
    logic             exp_ovf;
    logic             exp_unf;

    adder_5b u_exp_add (
        .carry(carry_s2),
        .exp1 (a_head_s2[EXP_W-1:0]),
        .exp2 (b_head_s2[EXP_W-1:0]),
        .sum  (exp_sum),
        .ovf  (exp_ovf),
        .unf  (exp_unf)
    );

    // On a carry the product is shifted right by one to renormalise.
    // frac_prod holds the ten fraction bits, then the guard bit, then one sticky bit.
    logic [FRAC_W+1:0] frac_prod;
    logic              sticky;
    logic              round_up;
    logic [FRAC_W-1:0] frac_rnd;
    logic [EXP_W-1:0]  exp_final;

    assign frac_prod = carry_s2 ? prod_s2[FRAC_W+2:1] : prod_s2[FRAC_W+1:0];

    // The bit shifted out on renormalisation still counts toward sticky.
    assign sticky = frac_prod[0] | loss_s2 | (carry_s2 & prod_s2[0]);

    // Round to nearest, ties to even.
    assign round_up = frac_prod[1] & (sticky | frac_prod[2]);

    // An all ones fraction wraps to zero here; the exponent is left alone.
    assign frac_rnd = frac_prod[FRAC_W+1:2] + {{(FRAC_W-1){1'b0}}, round_up};

    // A zero significand product gives a zero exponent field.
    assign exp_final = ({carry_s2, prod_s2} == '0) ? '0 : exp_sum;

    assign lane.done      = lat2_ready;
    assign lane.result    = {sign_r, exp_final, frac_rnd};
    assign lane.range_err = exp_ovf | exp_unf;

endmodule

`default_nettype wire

// File: rtl/op_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module op_dispatch import fp16_mul_pkg::*; (
    input  logic         clk,
    input  logic         nRST,
    input  logic         in_valid,
    input  logic [15:0]  in_a,
    input  logic [15:0]  in_b,
    output logic         in_credit,
    output logic         credit_err,
    input  logic         slot_free,
    mul_lane_if.dispatch lanes [NUM_LANES]
);

    // Copy of the producer's credit count, as seen from this side.
    logic [CNT_W-1:0]      credit_cnt;
    logic [LANE_IDX_W-1:0] rr_ptr;
    logic [NUM_LANES-1:0]  start_q;
    logic [15:0]           op_a_q;
    logic [15:0]           op_b_q;
    logic                  accept;

    // A send with no credit left is a protocol violation and is dropped.
    assign accept = in_valid && (credit_cnt != '0);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            credit_cnt <= CNT_W'(BUF_DEPTH);
            credit_err <= 1'b0;
            in_credit  <= 1'b0;
            rr_ptr     <= '0;
            start_q    <= '0;
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(accept) + CNT_W'(slot_free);
            // Sticky until reset.
            if (in_valid && (credit_cnt == '0)) begin
                credit_err <= 1'b1;
            end
            in_credit <= slot_free;
            start_q   <= '0;
            if (accept) begin
                start_q[rr_ptr] <= 1'b1;
                rr_ptr <= (rr_ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    // One operand register is shared by all lanes. Only the selected lane
    // sees a start, and it latches the pair in the same cycle.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a_q <= in_a;
            op_b_q <= in_b;
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane_drive
        assign lanes[g].start = start_q[g];
        assign lanes[g].a     = op_a_q;
        assign lanes[g].b     = op_b_q;
    end

endmodule

`default_nettype wire

// File: rtl/result_collect.sv
`timescale 1ns/10ps
`default_nettype none

module result_collect import fp16_mul_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    mul_lane_if.collect lanes [NUM_LANES],
    output logic        slot_free,
    output logic        out_valid,
    output logic [15:0] out_result,
    output logic        out_range_err,
    input  logic        out_credit
);

    logic [NUM_LANES-1:0] lane_done;
    logic [15:0]          lane_result [NUM_LANES];
    logic [NUM_LANES-1:0] lane_range;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane_read
        assign lane_done[g]   = lanes[g].done;
        assign lane_result[g] = lanes[g].result;
        assign lane_range[g]  = lanes[g].range_err;
    end

    // Each entry is the range flag above the 16-bit result.
    logic [16:0]           entry_mem [BUF_DEPTH];
    logic [BUF_IDX_W-1:0]  wr_ptr;
    logic [BUF_IDX_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]      fill_cnt;
    logic [CNT_W-1:0]      out_cred;
    logic [LANE_IDX_W-1:0] lane_ptr;
    logic                  push;
    logic                  pop;

    // Lanes finish in the order they were started, so watching one lane at a
    // time in issue order keeps the results in order.
    // At most one lane is done in any cycle.
    assign push = lane_done[lane_ptr];

    // A result leaves only when one is stored and downstream has a credit.
    assign pop       = (fill_cnt != '0) && (out_cred != '0);
    assign slot_free = pop;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill_cnt  <= '0;
            out_cred  <= CNT_W'(OUT_CREDITS);
            lane_ptr  <= '0;
            out_valid <= 1'b0;
        end else begin
            fill_cnt  <= fill_cnt + CNT_W'(push) - CNT_W'(pop);
            out_cred  <= out_cred - CNT_W'(pop) + CNT_W'(out_credit);
            out_valid <= pop;
            if (push) begin
                wr_ptr   <= wr_ptr + 1'b1;
                lane_ptr <= (lane_ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry_mem[wr_ptr] <= {lane_range[lane_ptr], lane_result[lane_ptr]};
        end
        if (pop) begin
            {out_range_err, out_result} <= entry_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/fp16_mul_array.sv
`timescale 1ns/10ps
`default_nettype none

module fp16_mul_array import fp16_mul_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  logic        in_valid,
    input  logic [15:0] in_a,
    input  logic [15:0] in_b,
    output logic        in_credit,
    output logic        out_valid,
    output logic [15:0] out_result,
    output logic        out_range_err,
    input  logic        out_credit,
    output logic        credit_err
);

    // Pulses once for every result handed downstream.
    logic slot_free;

    // One bundle per lane, shared by dispatcher, lane and collector.
    mul_lane_if lanes [NUM_LANES] ();

    op_dispatch u_op_dispatch (
        .clk       (clk),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_credit (in_credit),
        .credit_err(credit_err),
        .slot_free (slot_free),
        .lanes     (lanes)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lanes
        mul_fp16 u_mul_fp16 (
            .clk (clk),
            .nRST(nRST),
            .lane(lanes[g])
        );
    end

    result_collect u_result_collect (
        .clk          (clk),
        .nRST         (nRST),
        .lanes        (lanes),
        .slot_free    (slot_free),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_range_err(out_range_err),
        .out_credit   (out_credit)
    );

endmodule

`default_nettype wire

// File: test/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Free running clock for the testbench.
module clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half a period high, half a period low.
    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: test/fp16_mul_array_props.sv
`timescale 1ns/10ps
`default_nettype none

module fp16_mul_array_props import fp16_mul_pkg::*; (
    input wire                 clk,
    input wire                 nRST,
    input wire                 out_valid,
    input wire                 out_credit,
    input wire                 in_credit,
    input wire [NUM_LANES-1:0] lane_done
);

    // Credits the collector may still spend, seen from the consumer side.
    int out_avail;
    // Results handed downstream and credits handed upstream so far.
    int left_cnt;
    int up_cnt;

    always @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            out_avail <= OUT_CREDITS;
            left_cnt  <= 0;
            up_cnt    <= 0;
        end else begin
            out_avail <= out_avail - int'(out_valid) + int'(out_credit);
            left_cnt  <= left_cnt + int'(out_valid);
            up_cnt    <= up_cnt + int'(in_credit);
        end
    end

    // A result may only be sent while a downstream credit is held.
    a_out_needs_credit: assert property (@(posedge clk) disable iff (!nRST)
        out_valid |-> (out_avail > 0))
        else $error("out_valid without downstream credit");

    // Lanes are started one per cycle, so they also finish one per cycle.
    a_one_done: assert property (@(posedge clk) disable iff (!nRST)
        $onehot0(lane_done))
        else $error("more than one lane done in a cycle");

    // Each upstream credit matches one result that has left.
    a_credit_bound: assert property (@(posedge clk) disable iff (!nRST)
        in_credit |-> (up_cnt < left_cnt + int'(out_valid)))
        else $error("in_credit without a matching result");

endmodule

bind fp16_mul_array fp16_mul_array_props u_props (
    .clk       (clk),
    .nRST      (nRST),
    .out_valid (out_valid),
    .out_credit(out_credit),
    .in_credit (in_credit),
    .lane_done (u_result_collect.lane_done)
);

`default_nettype wire

// File: test/tb_fp16_mul_array.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fp16_mul_array import fp16_mul_pkg::*; ();

    // Clock edges from a sampled in_valid to a visible out_valid on an idle path.
    // Dispatch, two multiplier stages, lane output, buffer write, output register.
    localparam int IDLE_LATENCY = 5;
    localparam int WAIT_LIMIT   = 300;

    logic        clk;
    logic        nRST;
    logic        in_valid;
    logic [15:0] in_a;
    logic [15:0] in_b;
    logic        in_credit;
    logic        out_valid;
    logic [15:0] out_result;
    logic        out_range_err;
    logic        out_credit;
    logic        credit_err;

    int errors;
    int timeouts;
    int seed;
    // Upstream credit state as counts from two writers.
    int sent_cnt;
    int returned_cnt;
    // Downstream side: results seen and credits granted by the tests.
    int received;
    bit auto_credit;
    int credits_granted;
    int credits_sent;
    // Expected {range flag, result} in issue order.
    logic [16:0] exp_q[$];

    clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk(clk));

    fp16_mul_array u_fp16_mul_array (
        .clk          (clk),
        .nRST         (nRST),
        .in_valid     (in_valid),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_range_err(out_range_err),
        .out_credit   (out_credit),
        .credit_err   (credit_err)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    // Reference FP16 product. Returns the range flag above the 16-bit result.
    function automatic logic [16:0] ref_mul(input logic [15:0] a, input logic [15:0] b);
        int ea;
        int eb;
        int p;
        int carry;
        int frac;
        int g;
        int s;
        int raw;
        int e;
        bit rng;
        ea = int'(a[14:10]);
        eb = int'(b[14:10]);
        p = (((ea != 0) ? 1024 : 0) + int'(a[9:0])) * (((eb != 0) ? 1024 : 0) + int'(b[9:0]));
        carry = (p >> 21) & 1;
        if (carry == 1) begin
            frac = (p >> 11) & 1023;
            g = (p >> 10) & 1;
            s = ((p & 1023) != 0) ? 1 : 0;
        end else begin
            frac = (p >> 10) & 1023;
            g = (p >> 9) & 1;
            s = ((p & 511) != 0) ? 1 : 0;
        end
        // Ties go to the even fraction, and an all ones fraction wraps.
        if (g == 1 && (s == 1 || (frac & 1) == 1)) begin
            frac = (frac + 1) & 1023;
        end
        raw = ea + eb + carry;
        rng = (raw > 45) || (raw < 16);
        // The truncated product keeps the bits from 8 upward.
        e = ((p >> 8) == 0) ? 0 : ((raw - 15) & 31);
        return {rng, a[15] ^ b[15], e[4:0], frac[9:0]};
    endfunction

    // Consumer model. Checks every result and returns downstream credits.
    always @(negedge clk) begin
        out_credit = 1'b0;
        if (nRST) begin
            if (in_credit) begin
                returned_cnt++;
            end
            if (out_valid) begin
                received++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected result %h with nothing outstanding", out_result);
                    errors++;
                end else begin
                    check_value("out_result", 32'(out_result), 32'(exp_q[0][15:0]));
                    check_value("out_range_err", 32'(out_range_err), 32'(exp_q[0][16]));
                    void'(exp_q.pop_front());
                end
            end
            if (auto_credit && out_valid) begin
                out_credit = 1'b1;
            end else if (credits_sent < credits_granted) begin
                out_credit = 1'b1;
                credits_sent++;
            end
        end
    end

    // Sends one pair when the producer holds a credit, starting on a falling edge.
    task automatic send_op(input logic [15:0] a, input logic [15:0] b);
        int n;
        n = 0;
        while (BUF_DEPTH - sent_cnt + returned_cnt <= 0 && n < WAIT_LIMIT) begin
            in_valid = 1'b0;
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout waiting for an upstream credit");
            timeouts++;
        end else begin
            in_valid = 1'b1;
            in_a = a;
            in_b = b;
            sent_cnt++;
            exp_q.push_back(ref_mul(a, b));
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_received(input int target, input string what);
        int n;
        n = 0;
        while (received < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout waiting for results during %s", what);
            timeouts++;
        end
    endtask

    task automatic wait_drain(input string what);
        wait_received(received + exp_q.size(), what);
    endtask

    task automatic grant_one_credit();
        int n;
        credits_granted++;
        n = 0;
        while (credits_sent < credits_granted && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout handing a credit to the collector");
            timeouts++;
        end
    endtask

    function automatic logic [15:0] rand_normal();
        logic [15:0] v;
        v = 16'($random(seed));
        // Keep the exponent near the bias so most products stay in range.
        v[14:10] = 5'(8 + ($random(seed) & 15));
        return v;
    endfunction

    task automatic test_reset_single();
        int n;
        check_value("in_credit after reset", 32'(in_credit), 0);
        check_value("out_valid after reset", 32'(out_valid), 0);
        check_value("credit_err after reset", 32'(credit_err), 0);
        // 1.5 times 2.0.
        send_op(16'h3E00, 16'h4000);
        n = 0;
        while (!out_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("Timeout waiting for the single product");
            timeouts++;
        end else begin
            check_value("single latency", 32'(n), IDLE_LATENCY);
            check_value("single product", 32'(out_result), 32'h4200);
        end
        wait_drain("single operation");
    endtask

    task automatic test_full_pipeline();
        logic [15:0] a;
        logic [15:0] b;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            a = rand_normal();
            b = rand_normal();
            b[15] = i[1];
            send_op(a, b);
        end
        wait_drain("full pipeline");
    endtask

    task automatic test_rounding();
        send_op(16'h3C01, 16'h3E00);
        send_op(16'h3C03, 16'h3E00);
        send_op(16'h3C01, 16'h3E01);
        send_op(16'h3FFF, 16'h3FFF);
        send_op(16'h3FFE, 16'h3C01);
        send_op(16'h0000, 16'h4500);
        send_op(16'h8000, 16'h3C00);
        send_op(16'hBBFF, 16'h3C01);
        wait_drain("rounding edges");
    endtask

    task automatic test_range();
        send_op(16'h7800, 16'h7800);
        send_op(16'h0400, 16'h0400);
        send_op(16'h3C00, 16'h3C00);
        send_op(16'h5800, 16'h5800);
        send_op(16'h2000, 16'h1C00);
        send_op(16'hC400, 16'h3800);
        wait_drain("range flag");
    endtask

    task automatic test_backpressure();
        int rcv0;
        int ret0;
        rcv0 = received;
        ret0 = returned_cnt;
        auto_credit = 1'b0;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            send_op(rand_normal(), rand_normal());
        end
        wait_received(rcv0 + OUT_CREDITS, "stall fill");
        repeat (20) @(negedge clk);
        check_value("results before stall", 32'(received - rcv0), OUT_CREDITS);
        for (int i = 0; i < BUF_DEPTH; i++) begin
            grant_one_credit();
            if (i < BUF_DEPTH - OUT_CREDITS) begin
                wait_received(rcv0 + OUT_CREDITS + i + 1, "credit return");
            end
        end
        repeat (4) @(negedge clk);
        check_value("results after stall", 32'(received - rcv0), BUF_DEPTH);
        check_value("in_credit pulses", 32'(returned_cnt - ret0), 32'(received - rcv0));
        auto_credit = 1'b1;
    endtask

    task automatic test_credit_violation();
        int rcv0;
        rcv0 = received;
        auto_credit = 1'b0;
        for (int i = 0; i < BUF_DEPTH + OUT_CREDITS; i++) begin
            send_op(rand_normal(), rand_normal());
        end
        wait_received(rcv0 + OUT_CREDITS, "credit exhaustion");
        repeat (4) @(negedge clk);
        check_value("upstream credits left", 32'(BUF_DEPTH - sent_cnt + returned_cnt), 0);
        check_value("credit_err before violation", 32'(credit_err), 0);
        // A send with no credit. The DUT drops it, so nothing is expected.
        in_valid = 1'b1;
        in_a = 16'h3C00;
        in_b = 16'h3C00;
        @(negedge clk);
        in_valid = 1'b0;
        @(negedge clk);
        check_value("credit_err after violation", 32'(credit_err), 1);
        repeat (10) @(negedge clk);
        check_value("credit_err held", 32'(credit_err), 1);
        for (int i = 0; i < BUF_DEPTH; i++) begin
            grant_one_credit();
        end
        wait_drain("drain after violation");
    endtask

    initial begin
        #2_000_000;
        $display("Simulation ran past its time limit");
        $display("tests failed");
        $finish;
    end

    initial begin
        seed = 32'h67ed;
        nRST = 1'b0;
        in_valid = 1'b0;
        in_a = '0;
        in_b = '0;
        out_credit = 1'b0;
        auto_credit = 1'b1;
        repeat (5) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        test_reset_single();
        test_full_pipeline();
        test_rounding();
        test_range();
        test_backpressure();
        test_credit_violation();
        repeat (5) @(negedge clk);
        check_value("results outstanding", 32'(exp_q.size()), 0);
        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/fp16_mul_pkg.sv
rtl/mul_lane_if.sv
rtl/wallacetree_11b_2c.sv
rtl/adder_5b.sv
rtl/mul_fp16.sv
rtl/op_dispatch.sv
rtl/result_collect.sv
rtl/fp16_mul_array.sv
test/clk_gen.sv
test/fp16_mul_array_props.sv
test/tb_fp16_mul_array.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FP16 multiply array simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fp16_mul_array -f sim.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
